/* verilog/fp_types_pkg.sv */
// fp_types_pkg: single-precision number format, field types and packing helpers
package fp_types_pkg;

    // Field widths of the IEEE single-precision word
    parameter int fp_word_w = 32;
    parameter int fp_exp_w = 8;
    parameter int fp_mant_w = 24;
    parameter int fp_frac_w = fp_mant_w - 1;

    // Exponent bias and the all-ones exponent
    parameter int fp_exp_bias = 127;
    parameter int fp_exp_max = 255;

    typedef logic [fp_word_w-1:0] fp_word_t;
    typedef logic [fp_exp_w-1:0] fp_exp_t;
    typedef logic [fp_mant_w-1:0] fp_mant_t;
    typedef logic [fp_frac_w-1:0] fp_frac_t;

    // Two extra bits so overflow and underflow of a result exponent stay visible
    typedef logic signed [fp_exp_w+1:0] fp_exp_wide_t;

    // Unpacked operand, mantissa carries the hidden bit
    typedef struct packed {
        logic     sign;
        fp_exp_t  exp;
        fp_mant_t mant;
        logic     is_zero;
        logic     is_special;
    } fp_operand_t;

    typedef struct packed {
        logic exception;
        logic overflow;
        logic underflow;
    } fp_flags_t;

    // Quiet NaN returned for any infinity or NaN input
    parameter fp_word_t fp_qnan = 32'h7fc0_0000;

    // Range flags of a result exponent
    function automatic fp_flags_t fp_range_flags(input fp_exp_wide_t e);
        fp_flags_t f;
        f.exception = 1'b0;
        f.overflow = (e >= fp_exp_wide_t'(fp_exp_max));
        f.underflow = (e <= 0);
        return f;
    endfunction

    // Pack a truncated result, saturating to signed infinity or signed zero
    function automatic fp_word_t fp_pack(input logic sign, input fp_exp_wide_t e,
                                         input fp_frac_t frac);
        fp_word_t w;
        if (e >= fp_exp_wide_t'(fp_exp_max)) begin
            w = {sign, fp_exp_t'(fp_exp_max), fp_frac_t'(0)};
        end else if (e <= 0) begin
            w = {sign, fp_exp_t'(0), fp_frac_t'(0)};
        end else begin
            w = {sign, e[fp_exp_w-1:0], frac};
        end
        return w;
    endfunction

endpackage

/* verilog/alu_ops_pkg.sv */
// alu_ops_pkg: operation codes and the request and response transactions
package alu_ops_pkg;

    // Operation code carried with every request and result
    typedef enum logic [1:0] {
        op_add  = 2'd0,
        op_sub  = 2'd1,
        op_mul  = 2'd2,
        op_rsvd = 2'd3
    } alu_op_e;

    // Raw request at the top-level input
    typedef struct packed {
        fp_types_pkg::fp_word_t operand_a;
        fp_types_pkg::fp_word_t operand_b;
        alu_op_e                op;
    } alu_req_t;

    // Decoded request handed to the adder or the multiplier
    typedef struct packed {
        fp_types_pkg::fp_operand_t a;
        fp_types_pkg::fp_operand_t b;
        alu_op_e                   op;
    } unit_req_t;

    // Result word with its flags and the op that made it
    typedef struct packed {
        fp_types_pkg::fp_word_t  result;
        fp_types_pkg::fp_flags_t flags;
        alu_op_e                 op;
    } alu_resp_t;

endpackage

/* verilog/fp_operand_stage.sv */
// fp_operand_stage: registers a request, decodes its operands and steers it to a unit
module fp_operand_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  alu_ops_pkg::alu_req_t req,
    input  logic                  req_valid,
    output logic                  req_ready,
    output alu_ops_pkg::unit_req_t add_req,
    output logic                  add_valid,
    input  logic                  add_ready,
    output alu_ops_pkg::unit_req_t mul_req,
    output logic                  mul_valid,
    input  logic                  mul_ready
);

    alu_ops_pkg::unit_req_t next_req;
    alu_ops_pkg::unit_req_t req_q;
    logic                   valid_q;
    logic                   take;
    logic                   load;

    // Split a word into fields, denormals flush to zero
    function automatic fp_types_pkg::fp_operand_t unpack(input fp_types_pkg::fp_word_t w);
        fp_types_pkg::fp_operand_t o;
        o.sign = w[31];
        o.exp = w[30:23];
        o.is_zero = (o.exp == '0);
        o.is_special = (o.exp == fp_types_pkg::fp_exp_t'(fp_types_pkg::fp_exp_max));
        o.mant = o.is_zero ? '0 : {1'b1, w[22:0]};
        return o;
    endfunction

    // Decode on the way in, subtraction becomes addition of a negated B
    always_comb begin
        next_req.a = unpack(req.operand_a);
        next_req.b = unpack(req.operand_b);
        next_req.op = req.op;
        if (req.op == alu_ops_pkg::op_sub) begin
            next_req.b.sign = ~next_req.b.sign;
        end
    end

    // Only the target unit sees valid
    assign add_valid = valid_q && (req_q.op == alu_ops_pkg::op_add ||
                                   req_q.op == alu_ops_pkg::op_sub);
    assign mul_valid = valid_q && (req_q.op == alu_ops_pkg::op_mul);

    // Register empties on a unit handshake, reserved ops leave on their own
    assign take = (add_valid && add_ready) || (mul_valid && mul_ready) ||
                  (valid_q && req_q.op == alu_ops_pkg::op_rsvd);
    assign req_ready = !valid_q || take;
    assign load = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (load) begin
            valid_q <= 1'b1;
        end else if (take) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            req_q <= next_req;
        end
    end

    // Both units see the same payload
    assign add_req = req_q;
    assign mul_req = req_q;

endmodule

/* verilog/fp_add_unit.sv */
// Floating-point add unit that aligns, adds, normalizes, truncates and packs in a pipeline
module fp_add_unit #(
    parameter int add_stages = 2
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  alu_ops_pkg::unit_req_t in_req,
    input  logic                   in_valid,
    output logic                   in_ready,
    output alu_ops_pkg::alu_resp_t out_resp,
    output logic                   out_valid,
    input  logic                   out_ready
);

    fp_types_pkg::fp_operand_t    big;
    fp_types_pkg::fp_operand_t    small_op;
    fp_types_pkg::fp_exp_t        exp_diff;
    logic [4:0]                   shift;
    fp_types_pkg::fp_mant_t       small_m;
    logic [24:0]                  sum;
    logic [4:0]                   lz;
    logic [24:0]                  norm;
    fp_types_pkg::fp_exp_wide_t   exp_res;
    alu_ops_pkg::alu_resp_t       stage_resp;

    alu_ops_pkg::alu_resp_t       resp_q [add_stages];
    logic [add_stages-1:0]        valid_q;
    logic                         advance;

    // Leading zero count of the 25-bit magnitude
    function automatic logic [4:0] lzc25(input logic [24:0] v);
        logic [4:0] n;
        n = 5'd25;
        for (int i = 0; i < 25; i++) begin
            if (v[i]) begin
                n = 5'(24 - i);
            end
        end
        return n;
    endfunction

    always_comb begin
        // Larger magnitude goes first and ties keep A
        if ({in_req.a.exp, in_req.a.mant} >= {in_req.b.exp, in_req.b.mant}) begin
            big = in_req.a;
            small_op = in_req.b;
        end else begin
            big = in_req.b;
            small_op = in_req.a;
        end

        // Alignment shift saturates once every bit is gone
        exp_diff = big.exp - small_op.exp;
        shift = (exp_diff > 8'd25) ? 5'd25 : exp_diff[4:0];
        small_m = small_op.mant >> shift;

        // Add or subtract magnitudes by sign so the sum never goes negative
        if (big.sign == small_op.sign) begin
            sum = {1'b0, big.mant} + {1'b0, small_m};
        end else begin
            sum = {1'b0, big.mant} - {1'b0, small_m};
        end

        // Leading one moves to bit 24 and a carry gives lz of 0
        lz = lzc25(sum);
        norm = sum << lz;
        exp_res = $signed({2'b00, big.exp}) + 10'sd1 - $signed({5'b00000, lz});

        stage_resp.op = in_req.op;
        stage_resp.flags = '0;
        if (in_req.a.is_special || in_req.b.is_special) begin
            stage_resp.result = fp_types_pkg::fp_qnan;
            stage_resp.flags.exception = 1'b1;
        end else if (sum == '0) begin
            // Exact cancellation is +0 with no flag
            stage_resp.result = '0;
        end else begin
            stage_resp.result = fp_types_pkg::fp_pack(big.sign, exp_res, norm[23:1]);
            stage_resp.flags = fp_types_pkg::fp_range_flags(exp_res);
        end
    end

    // Whole pipe moves together unless the last result is stuck
    assign advance = !valid_q[add_stages-1] || out_ready;
    assign in_ready = advance;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (advance) begin
            for (int i = add_stages - 1; i > 0; i--) begin
                valid_q[i] <= valid_q[i-1];
            end
            valid_q[0] <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            for (int i = add_stages - 1; i > 0; i--) begin
                resp_q[i] <= resp_q[i-1];
            end
            resp_q[0] <= stage_resp;
        end
    end

    assign out_resp = resp_q[add_stages-1];
    assign out_valid = valid_q[add_stages-1];

endmodule

/* verilog/fp_mul_unit.sv */
// fp_mul_unit: pipelined single-precision multiplier with truncation and flush-to-zero
module fp_mul_unit #(
    parameter int mul_stages = 3
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  alu_ops_pkg::unit_req_t in_req,
    input  logic                   in_valid,
    output logic                   in_ready,
    output alu_ops_pkg::alu_resp_t out_resp,
    output logic                   out_valid,
    input  logic                   out_ready
);

    logic [47:0]                  product;
    logic                         sign;
    fp_types_pkg::fp_exp_wide_t   exp_res;
    fp_types_pkg::fp_frac_t       frac;
    alu_ops_pkg::alu_resp_t       stage_resp;

    alu_ops_pkg::alu_resp_t       resp_q [mul_stages];
    logic [mul_stages-1:0]        valid_q;
    logic                         advance;

    always_comb begin
        product = in_req.a.mant * in_req.b.mant;
        sign = in_req.a.sign ^ in_req.b.sign;

        // Product of two 1.x values is in [1, 4), bit 47 bumps the exponent
        exp_res = $signed({2'b00, in_req.a.exp}) + $signed({2'b00, in_req.b.exp})
                - fp_types_pkg::fp_exp_wide_t'(fp_types_pkg::fp_exp_bias)
                + $signed({9'd0, product[47]});

        // Fraction below the leading one, low bits truncated
        frac = product[47] ? product[46:24] : product[45:23];

        stage_resp.op = in_req.op;
        stage_resp.flags = '0;
        if (in_req.a.is_special || in_req.b.is_special) begin
            stage_resp.result = fp_types_pkg::fp_qnan;
            stage_resp.flags.exception = 1'b1;
        end else if (in_req.a.is_zero || in_req.b.is_zero) begin
            // Flushed or true zero input, signed zero out
            stage_resp.result = {sign, 31'd0};
        end else begin
            stage_resp.result = fp_types_pkg::fp_pack(sign, exp_res, frac);
            stage_resp.flags = fp_types_pkg::fp_range_flags(exp_res);
        end
    end

    // Same stall scheme as the adder
    assign advance = !valid_q[mul_stages-1] || out_ready;
    assign in_ready = advance;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (advance) begin
            for (int i = mul_stages - 1; i > 0; i--) begin
                valid_q[i] <= valid_q[i-1];
            end
            valid_q[0] <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            for (int i = mul_stages - 1; i > 0; i--) begin
                resp_q[i] <= resp_q[i-1];
            end
            resp_q[0] <= stage_resp;
        end
    end

    assign out_resp = resp_q[mul_stages-1];
    assign out_valid = valid_q[mul_stages-1];

endmodule

/* verilog/fp_result_merge.sv */
// fp_result_merge: joins adder and multiplier results onto one output, adder first
module fp_result_merge (
    input  alu_ops_pkg::alu_resp_t add_resp,
    input  logic                   add_resp_valid,
    output logic                   add_resp_ready,
    input  alu_ops_pkg::alu_resp_t mul_resp,
    input  logic                   mul_resp_valid,
    output logic                   mul_resp_ready,
    output alu_ops_pkg::alu_resp_t resp,
    output logic                   resp_valid,
    input  logic                   resp_ready
);

    // Adder wins whenever it holds a result
    assign resp_valid = add_resp_valid || mul_resp_valid;
    assign resp = add_resp_valid ? add_resp : mul_resp;

    // Ready goes only to the unit being forwarded
    assign add_resp_ready = add_resp_valid && resp_ready;

    // Multiplier waits while the adder has something
    assign mul_resp_ready = mul_resp_valid && !add_resp_valid && resp_ready;

endmodule

/* verilog/fp_alu_top.sv */
// fp_alu_top: floating-point ALU with ready-valid request and response streams
module fp_alu_top #(
    parameter int add_stages = 2,
    parameter int mul_stages = 3
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  alu_ops_pkg::alu_req_t  req,
    input  logic                   req_valid,
    output logic                   req_ready,
    output alu_ops_pkg::alu_resp_t resp,
    output logic                   resp_valid,
    input  logic                   resp_ready
);

    // Operand stage to units
    alu_ops_pkg::unit_req_t add_req;
    alu_ops_pkg::unit_req_t mul_req;
    logic                   add_valid;
    logic                   add_ready;
    logic                   mul_valid;
    logic                   mul_ready;

    // Units to merge stage
    alu_ops_pkg::alu_resp_t add_resp;
    alu_ops_pkg::alu_resp_t mul_resp;
    logic                   add_resp_valid;
    logic                   add_resp_ready;
    logic                   mul_resp_valid;
    logic                   mul_resp_ready;

    fp_operand_stage operand_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .add_req   (add_req),
        .add_valid (add_valid),
        .add_ready (add_ready),
        .mul_req   (mul_req),
        .mul_valid (mul_valid),
        .mul_ready (mul_ready)
    );

    fp_add_unit #(
        .add_stages (add_stages)
    ) add_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_req    (add_req),
        .in_valid  (add_valid),
        .in_ready  (add_ready),
        .out_resp  (add_resp),
        .out_valid (add_resp_valid),
        .out_ready (add_resp_ready)
    );

    fp_mul_unit #(
        .mul_stages (mul_stages)
    ) mul_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_req    (mul_req),
        .in_valid  (mul_valid),
        .in_ready  (mul_ready),
        .out_resp  (mul_resp),
        .out_valid (mul_resp_valid),
        .out_ready (mul_resp_ready)
    );

    fp_result_merge merge_i (
        .add_resp       (add_resp),
        .add_resp_valid (add_resp_valid),
        .add_resp_ready (add_resp_ready),
        .mul_resp       (mul_resp),
        .mul_resp_valid (mul_resp_valid),
        .mul_resp_ready (mul_resp_ready),
        .resp           (resp),
        .resp_valid     (resp_valid),
        .resp_ready     (resp_ready)
    );

endmodule

/* tb/fp_alu_tb.sv */
// Floating-point ALU testbench with random requests checked against a reference model
module fp_alu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int add_stages = 2;
    localparam int mul_stages = 3;
    localparam logic [31:0] seed = 32'hba76ed78;

    // Request counts per phase
    localparam int n_add = 300;
    localparam int n_mul = 300;
    localparam int n_edge = 100;
    localparam int n_mixed = 400;
    localparam int num_reqs = n_add + n_mul + n_edge + n_mixed;
    localparam int cycle_limit = num_reqs * (4 + mul_stages) * 4 + 200;

    logic                   clk;
    logic                   rst_n;
    alu_ops_pkg::alu_req_t  req;
    logic                   req_valid;
    logic                   req_ready;
    alu_ops_pkg::alu_resp_t resp;
    logic                   resp_valid;
    logic                   resp_ready;

    // Expected results in one queue per unit
    alu_ops_pkg::alu_resp_t add_q[$];
    alu_ops_pkg::alu_resp_t mul_q[$];

    logic [31:0] stim_state;
    logic [31:0] ready_state;
    logic        stall_mode = 1'b0;
    int          cycle_count = 0;
    int          add_seen = 0;
    int          mul_seen = 0;
    int          rsvd_seen = 0;

    fp_alu_top #(
        .add_stages (add_stages),
        .mul_stages (mul_stages)
    ) dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .resp       (resp),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Stimulus stream for the main process only
    function automatic logic [31:0] next_random();
        stim_state = xorshift32(stim_state);
        return stim_state;
    endfunction

    task automatic abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_word(input string name, input fp_types_pkg::fp_word_t got,
                              input fp_types_pkg::fp_word_t want);
        if (got !== want) begin
            $display("[FAIL] %s got %h expected %h", name, got, want);
            abort_run();
        end
    endtask

    task automatic check_flags(input string name, input fp_types_pkg::fp_flags_t got,
                               input fp_types_pkg::fp_flags_t want);
        if (got !== want) begin
            $display("[FAIL] %s got %h expected %h", name, got, want);
            abort_run();
        end
    endtask

    task automatic check_op(input string name, input alu_ops_pkg::alu_op_e got,
                            input alu_ops_pkg::alu_op_e want);
        if (got !== want) begin
            $display("[FAIL] %s got %h expected %h", name, got, want);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("[FAIL] %s got %h expected %h", name, got, want);
            abort_run();
        end
    endtask

    // Saturates to signed infinity or signed zero or packs the fields as they are
    function automatic alu_ops_pkg::alu_resp_t range_result(input alu_ops_pkg::alu_op_e op,
                                                            input logic sign, input int e,
                                                            input logic [22:0] frac);
        alu_ops_pkg::alu_resp_t r;
        r.op = op;
        r.flags = '0;
        if (e >= 255) begin
            r.result = {sign, 8'hff, 23'd0};
            r.flags.overflow = 1'b1;
        end else if (e <= 0) begin
            r.result = {sign, 31'd0};
            r.flags.underflow = 1'b1;
        end else begin
            r.result = {sign, 8'(e), frac};
        end
        return r;
    endfunction

    function automatic alu_ops_pkg::alu_resp_t nan_result(input alu_ops_pkg::alu_op_e op);
        alu_ops_pkg::alu_resp_t r;
        r.op = op;
        r.flags = '0;
        r.flags.exception = 1'b1;
        r.result = 32'h7fc0_0000;
        return r;
    endfunction

    function automatic alu_ops_pkg::alu_resp_t model_add(input fp_types_pkg::fp_word_t a,
                                                         input fp_types_pkg::fp_word_t b,
                                                         input alu_ops_pkg::alu_op_e op);
        alu_ops_pkg::alu_resp_t r;
        logic        sa;
        logic        sb;
        logic        sign;
        int          ea;
        int          eb;
        int          big_e;
        int          diff;
        int          lead;
        logic [23:0] ma;
        logic [23:0] mb;
        logic [23:0] big_m;
        logic [23:0] small_m;
        logic [24:0] mag;
        ea = int'(a[30:23]);
        eb = int'(b[30:23]);
        sa = a[31];
        // Subtract is an add of B with its sign flipped
        sb = b[31] ^ (op == alu_ops_pkg::op_sub);
        if (ea == 255 || eb == 255) begin
            r = nan_result(op);
        end else begin
            // Exponent 0 flushes to zero
            ma = (ea == 0) ? 24'd0 : {1'b1, a[22:0]};
            mb = (eb == 0) ? 24'd0 : {1'b1, b[22:0]};
            if (ea > eb || (ea == eb && ma >= mb)) begin
                sign = sa;
                big_e = ea;
                big_m = ma;
                small_m = mb;
                diff = ea - eb;
            end else begin
                sign = sb;
                big_e = eb;
                big_m = mb;
                small_m = ma;
                diff = eb - ea;
            end
            if (diff > 25) begin
                diff = 25;
            end
            small_m = small_m >> diff;
            if (sa == sb) begin
                mag = {1'b0, big_m} + {1'b0, small_m};
            end else begin
                mag = {1'b0, big_m} - {1'b0, small_m};
            end
            if (mag == 25'd0) begin
                r.op = op;
                r.flags = '0;
                r.result = '0;
            end else begin
                // Walk the leading one up to bit 24 and count its position
                lead = 24;
                while (mag[24] == 1'b0) begin
                    mag = mag << 1;
                    lead = lead - 1;
                end
                r = range_result(op, sign, big_e + lead - 23, mag[23:1]);
            end
        end
        return r;
    endfunction

    function automatic alu_ops_pkg::alu_resp_t model_mul(input fp_types_pkg::fp_word_t a,
                                                         input fp_types_pkg::fp_word_t b);
        alu_ops_pkg::alu_resp_t r;
        logic        sign;
        int          ea;
        int          eb;
        int          e;
        logic [47:0] p;
        logic [47:0] top;
        ea = int'(a[30:23]);
        eb = int'(b[30:23]);
        sign = a[31] ^ b[31];
        if (ea == 255 || eb == 255) begin
            r = nan_result(alu_ops_pkg::op_mul);
        end else if (ea == 0 || eb == 0) begin
            r.op = alu_ops_pkg::op_mul;
            r.flags = '0;
            r.result = {sign, 31'd0};
        end else begin
            p = {24'd0, 1'b1, a[22:0]} * {24'd0, 1'b1, b[22:0]};
            // Product lies in [1, 4) and keeps 23 bits under the leading one
            if (p[47]) begin
                e = ea + eb - 126;
                top = p >> 24;
            end else begin
                e = ea + eb - 127;
                top = p >> 23;
            end
            r = range_result(alu_ops_pkg::op_mul, sign, e, top[22:0]);
        end
        return r;
    endfunction

    function automatic fp_types_pkg::fp_word_t normal_word();
        logic [31:0] r;
        logic [31:0] e;
        r = next_random();
        e = 32'd1 + (next_random() % 32'd254);
        return {r[31], e[7:0], r[22:0]};
    endfunction

    // Exponent close to the reference so mantissas overlap
    function automatic fp_types_pkg::fp_word_t nearby_word(input fp_types_pkg::fp_word_t ref_w);
        logic [31:0] r;
        int          e;
        r = next_random();
        e = int'(ref_w[30:23]) + int'(r[5:0]) - 32;
        if (e < 1) begin
            e = 1;
        end
        if (e > 254) begin
            e = 254;
        end
        return {r[31], 8'(e), r[30:8]};
    endfunction

    // Picks a zero, denormal, infinity, NaN or normal word
    function automatic fp_types_pkg::fp_word_t edge_word();
        logic [31:0]            r;
        logic [22:0]            frac;
        fp_types_pkg::fp_word_t w;
        r = next_random();
        frac = r[26] ? r[22:0] : 23'd0;
        case (r[29:27])
            3'd0, 3'd1: w = {r[31], 8'h00, frac};
            3'd2, 3'd3: w = {r[31], 8'hff, frac};
            default: w = normal_word();
        endcase
        return w;
    endfunction

    // Starts at a falling edge and returns at the falling edge after the transfer
    task automatic send(input fp_types_pkg::fp_word_t a, input fp_types_pkg::fp_word_t b,
                        input alu_ops_pkg::alu_op_e op);
        logic accepted;
        req.operand_a = a;
        req.operand_b = b;
        req.op = op;
        req_valid = 1'b1;
        accepted = 1'b0;
        while (!accepted) begin
            @(posedge clk);
            accepted = req_ready;
        end
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic compare_response(input alu_ops_pkg::alu_resp_t want);
        check_op("resp.op", resp.op, want.op);
        check_word("resp.result", resp.result, want.result);
        check_flags("resp.flags", resp.flags, want.flags);
    endtask

    // Match the result against the head of its unit queue
    task automatic check_response();
        case (resp.op)
            alu_ops_pkg::op_mul: begin
                if (mul_q.size() == 0) begin
                    $display("Multiplier result arrived with no multiply outstanding");
                    abort_run();
                end else begin
                    mul_seen++;
                    compare_response(mul_q.pop_front());
                end
            end
            alu_ops_pkg::op_add, alu_ops_pkg::op_sub: begin
                if (add_q.size() == 0) begin
                    $display("Adder result arrived with no add or subtract outstanding");
                    abort_run();
                end else begin
                    add_seen++;
                    compare_response(add_q.pop_front());
                end
            end
            default: begin
                $display("A result came out carrying the reserved op code");
                abort_run();
            end
        endcase
    endtask

    task automatic record_request();
        case (req.op)
            alu_ops_pkg::op_add, alu_ops_pkg::op_sub: begin
                add_q.push_back(model_add(req.operand_a, req.operand_b, req.op));
            end
            alu_ops_pkg::op_mul: add_to_mul_queue();
            default: rsvd_seen++;
        endcase
    endtask

    task automatic add_to_mul_queue();
        mul_q.push_back(model_mul(req.operand_a, req.operand_b));
    endtask

    // Results are checked before the request of the same edge is recorded
    always @(posedge clk) begin
        if (rst_n) begin
            if (resp_valid && resp_ready) begin
                check_response();
            end
            if (req_valid && req_ready) begin
                record_request();
            end
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout, the run went past %0d cycles", cycle_limit);
            abort_run();
        end
    end

    // Output back-pressure from its own random stream
    initial begin
        resp_ready = 1'b1;
        ready_state = seed ^ 32'hffff_ffff;
        forever begin
            @(negedge clk);
            if (stall_mode) begin
                ready_state = xorshift32(ready_state);
                // Low on about 40 percent of cycles
                resp_ready = (ready_state % 32'd10) >= 32'd4;
            end else begin
                resp_ready = 1'b1;
            end
        end
    end

    initial begin
        fp_types_pkg::fp_word_t a;
        fp_types_pkg::fp_word_t b;
        logic [31:0]            r;
        alu_ops_pkg::alu_op_e   op;
        rst_n = 1'b0;
        req = '0;
        req_valid = 1'b0;
        stim_state = seed;

        // Outputs idle through reset and the cycle after
        repeat (5) begin
            @(negedge clk);
            check_bit("resp_valid", resp_valid, 1'b0);
            check_bit("req_ready", req_ready, 1'b1);
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_bit("resp_valid", resp_valid, 1'b0);
        check_bit("req_ready", req_ready, 1'b1);

        // Add and subtract where one in eight cancels exactly
        repeat (n_add) begin
            r = next_random();
            a = normal_word();
            if (r[2:0] == 3'd0) begin
                b = r[3] ? a : {~a[31], a[30:0]};
                op = r[3] ? alu_ops_pkg::op_sub : alu_ops_pkg::op_add;
            end else begin
                b = r[4] ? nearby_word(a) : normal_word();
                op = r[5] ? alu_ops_pkg::op_sub : alu_ops_pkg::op_add;
            end
            send(a, b, op);
        end

        // Full exponent range makes overflow and underflow both common
        repeat (n_mul) begin
            a = normal_word();
            b = normal_word();
            send(a, b, alu_ops_pkg::op_mul);
        end

        // Special and zero encodings on all three ops
        repeat (n_edge) begin
            r = next_random();
            a = edge_word();
            b = edge_word();
            op = alu_ops_pkg::alu_op_e'((r[1:0] == 2'd3) ? 2'd2 : r[1:0]);
            send(a, b, op);
        end

        // Back-pressure on with reserved ops mixed in
        @(posedge clk);
        stall_mode = 1'b1;
        @(negedge clk);
        repeat (n_mixed) begin
            r = next_random();
            a = (r[9:8] == 2'd0) ? edge_word() : normal_word();
            b = (r[11:10] == 2'd0) ? edge_word() : normal_word();
            case (r[2:0])
                3'd0: op = alu_ops_pkg::op_rsvd;
                3'd1, 3'd2, 3'd3: op = alu_ops_pkg::op_mul;
                3'd4, 3'd5: op = alu_ops_pkg::op_add;
                default: op = alu_ops_pkg::op_sub;
            endcase
            send(a, b, op);
        end

        // Drain under back-pressure and then wait a quiet spell to catch duplicates
        while (add_q.size() != 0 || mul_q.size() != 0) begin
            @(negedge clk);
        end
        @(posedge clk);
        stall_mode = 1'b0;
        repeat (20) @(negedge clk);

        $display("Checked %0d add results and %0d mul results, %0d reserved dropped",
                 add_seen, mul_seen, rsvd_seen);
        if (resp_valid === 1'b0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("Output still busy after the drain");
            abort_run();
        end
    end

endmodule

/* compile.f */
verilog/fp_types_pkg.sv
verilog/alu_ops_pkg.sv
verilog/fp_operand_stage.sv
verilog/fp_add_unit.sv
verilog/fp_mul_unit.sv
verilog/fp_result_merge.sv
verilog/fp_alu_top.sv
tb/fp_alu_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = fp_alu_tb
FILELIST  = compile.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = ALL TESTS PASSED

.PHONY: simulate clean

# The run is judged by the log, so a crash or early stop counts as failure
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
